// ==== all.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/mem_if.sv
hw/word_memory.sv
hw/register_file.sv
hw/instr_decoder.sv
hw/exec_unit.sv
hw/cpu_control.sv
hw/cpu_top.sv
test/tb_cpu.sv

// ==== hw/cpu_consts.svh ====
// Sizes of the core and its two memories
// CPU_MEM_DEPTH must stay equal to 2**CPU_MEM_ADDR_W, and the same holds for the registers
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Width of every data word, instruction word and register
`define CPU_WORD_W 32

// Instruction memory and data memory have the same depth
`define CPU_MEM_DEPTH 256
`define CPU_MEM_ADDR_W 8

// General purpose register file
`define CPU_REG_COUNT 32
`define CPU_REG_ADDR_W 5

`endif

// ==== hw/cpu_control.sv ====
// Loader and multi-cycle run FSM, sharing both memory write ports
// More than 255 instructions wraps the instruction count and is not checked
`timescale 1ns/1ps

module cpu_control (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_valid,
    input  cpu_pkg::word_t     load_data,
    input  logic               load_to_data,
    input  logic               start,
    input  cpu_pkg::op_class_t op_class,
    input  cpu_pkg::reg_addr_t rs,
    input  cpu_pkg::reg_addr_t rt,
    input  cpu_pkg::reg_addr_t rd,
    input  cpu_pkg::word_t     result,
    input  cpu_pkg::mem_addr_t mem_addr,
    input  cpu_pkg::mem_addr_t next_pc,
    output logic               load_ready,
    output logic               done,
    mem_if.ctrl                imem,
    mem_if.ctrl                dmem,
    output cpu_pkg::word_t     ir,
    output cpu_pkg::mem_addr_t pc,
    output cpu_pkg::reg_addr_t rs_addr,
    output cpu_pkg::reg_addr_t rt_addr,
    output logic               wr_en,
    output cpu_pkg::reg_addr_t wr_addr,
    output cpu_pkg::word_t     wr_data
);
    import cpu_pkg::*;

    ctrl_state_t state;
    mem_addr_t   instr_count;
    mem_addr_t   data_count;
    logic        load_fire;
    logic        store_fire;

    // No back-pressure while loading, and none accepted after start
    assign load_ready = (state == LOAD);
    assign load_fire  = load_valid && load_ready;
    assign store_fire = (state == EXECUTE) && (op_class == STORE_WORD);

    // Instruction memory is written only by the loader and read at the PC
    assign imem.we    = load_fire && !load_to_data;
    assign imem.waddr = instr_count;
    assign imem.wdata = load_data;
    assign imem.raddr = pc;

    // Data memory write port is shared between loader and sw
    assign dmem.we    = (load_fire && load_to_data) || store_fire;
    assign dmem.waddr = store_fire ? mem_addr : data_count;
    assign dmem.wdata = store_fire ? result : load_data;
    // The lw address is presented in EXECUTE, the word arrives in MEM_WAIT
    assign dmem.raddr = mem_addr;

    assign rs_addr = rs;
    assign rt_addr = rt;

    // Register form writes rd, immediate form and lw write rt
    always_comb begin
        wr_en   = 1'b0;
        wr_addr = rt;
        wr_data = result;
        if (state == EXECUTE) begin
            wr_en   = (op_class == ALU_REG) || (op_class == ALU_IMM);
            wr_addr = (op_class == ALU_REG) ? rd : rt;
        end else if (state == MEM_WAIT) begin
            wr_en   = 1'b1;
            wr_data = dmem.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= LOAD;
            pc          <= '0;
            instr_count <= '0;
            data_count  <= '0;
            done        <= 1'b0;
        end else begin
            case (state)
                LOAD: begin
                    // Both memories fill from address 0 upward
                    if (load_fire) begin
                        if (load_to_data) begin
                            data_count <= data_count + 1'b1;
                        end else begin
                            instr_count <= instr_count + 1'b1;
                        end
                    end
                    // A word accepted together with start is still stored
                    if (start) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (pc >= instr_count) begin
                        state <= HALT;
                        done  <= 1'b1;
                    end else begin
                        state <= DECODE;
                    end
                end
                DECODE: state <= EXECUTE;
                EXECUTE: begin
                    pc    <= next_pc;
                    state <= (op_class == LOAD_WORD) ? MEM_WAIT : FETCH;
                end
                MEM_WAIT: state <= FETCH;
                default: state <= HALT;
            endcase
        end
    end

    // The fetched word is on the memory output during DECODE
    always_ff @(posedge clk) begin
        if (state == DECODE) begin
            ir <= imem.rdata;
        end
    end

    // Once the program ends the core stays halted until the next reset
    done_sticky_a: assert property (
        @(posedge clk) disable iff (!rst_n) $fell(done) |-> !$past(rst_n)
    );

endmodule

// ==== hw/cpu_pkg.sv ====
// Types shared by the core modules and the testbench
// Opcode enum values are the 6-bit opcodes of the load/store instruction set
`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;
    typedef logic [`CPU_MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [15:0] imm_t;

    // Kept opcodes first, then the dropped ones that decode to a no-op
    typedef enum logic [5:0] {
        OP_RTYPE   = 6'd0,
        OP_ADDI    = 6'd1,
        OP_AND     = 6'd3,
        OP_OR      = 6'd4,
        OP_ANDI    = 6'd5,
        OP_ORI     = 6'd6,
        OP_SHIFT   = 6'd7,
        OP_LW      = 6'd8,
        OP_SW      = 6'd9,
        OP_BEQ     = 6'd10,
        OP_BNE     = 6'd11,
        OP_J       = 6'd16,
        OP_SLT     = 6'd19,
        OP_SLTI    = 6'd20,
        OP_ADDIU   = 6'd2,
        OP_BGT     = 6'd12,
        OP_JR      = 6'd17,
        OP_JAL     = 6'd18,
        OP_SYSCALL = 6'd21
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_REG, ALU_IMM, LOAD_WORD, STORE_WORD, BRANCH_EQ, BRANCH_NE, JUMP, NOP
    } op_class_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_SRL, ALU_SLT
    } alu_op_t;

    typedef enum logic [2:0] {
        LOAD, FETCH, DECODE, EXECUTE, MEM_WAIT, HALT
    } ctrl_state_t;

endpackage

// ==== hw/cpu_top.sv ====
// Core top level with the load stream, start/done and the inspection port
// Register inspection uses the low 5 bits of insp_addr
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_valid,
    input  cpu_pkg::word_t     load_data,
    input  logic               load_to_data,
    output logic               load_ready,
    input  logic               start,
    output logic               done,
    input  logic               insp_is_mem,
    input  cpu_pkg::mem_addr_t insp_addr,
    output cpu_pkg::word_t     insp_data
);
    import cpu_pkg::*;

    word_t      ir, rs_val, rt_val, result, wr_data, rf_insp, dmem_insp;
    mem_addr_t  pc, jump_target, mem_addr, next_pc;
    reg_addr_t  rs, rt, rd, rs_addr, rt_addr, wr_addr;
    op_class_t  op_class;
    alu_op_t    alu_op;
    imm_t       imm;
    logic [4:0] shamt;
    logic       wr_en;

    mem_if imem_bus ();
    mem_if dmem_bus ();

    cpu_control ctrl_i (.clk, .rst_n, .load_valid, .load_data, .load_to_data, .start,
        .op_class, .rs, .rt, .rd, .result, .mem_addr, .next_pc, .load_ready, .done,
        .imem(imem_bus.ctrl), .dmem(dmem_bus.ctrl), .ir, .pc, .rs_addr, .rt_addr,
        .wr_en, .wr_addr, .wr_data);

    // Instruction memory has no visible inspection path at the top
    word_memory imem_i (.clk, .bus(imem_bus.mem), .insp_addr, .insp_data());
    word_memory dmem_i (.clk, .bus(dmem_bus.mem), .insp_addr, .insp_data(dmem_insp));

    register_file regs_i (.clk, .rst_n, .rs_addr, .rt_addr, .wr_en, .wr_addr, .wr_data,
        .insp_addr(insp_addr[`CPU_REG_ADDR_W-1:0]), .rs_data(rs_val), .rt_data(rt_val),
        .insp_data(rf_insp));

    instr_decoder dec_i (.ir, .op_class, .alu_op, .rs, .rt, .rd, .shamt, .imm, .jump_target);

    exec_unit exec_i (.op_class, .alu_op, .rs_val, .rt_val, .imm, .shamt, .pc, .jump_target,
        .result, .mem_addr, .next_pc);

    assign insp_data = insp_is_mem ? dmem_insp : rf_insp;

endmodule

// ==== hw/exec_unit.sv ====
// ALU, branch compare and address adder for the instruction in the IR
// PC and data addresses wrap modulo the memory depth
`timescale 1ns/1ps
`include "cpu_consts.svh"

module exec_unit (
    input  cpu_pkg::op_class_t op_class,
    input  cpu_pkg::alu_op_t   alu_op,
    input  cpu_pkg::word_t     rs_val,
    input  cpu_pkg::word_t     rt_val,
    input  cpu_pkg::imm_t      imm,
    input  logic [4:0]         shamt,
    input  cpu_pkg::mem_addr_t pc,
    input  cpu_pkg::mem_addr_t jump_target,
    output cpu_pkg::word_t     result,
    output cpu_pkg::mem_addr_t mem_addr,
    output cpu_pkg::mem_addr_t next_pc
);
    import cpu_pkg::*;

    word_t imm_ext;
    word_t op_b;
    word_t alu_out;
    logic  taken;

    // Every immediate is sign extended, the logical ones as well
    assign imm_ext = {{(`CPU_WORD_W - 16){imm[15]}}, imm};
    assign op_b    = (op_class == ALU_IMM) ? imm_ext : rt_val;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_out = rs_val - op_b;
            ALU_AND: alu_out = rs_val & op_b;
            ALU_OR:  alu_out = rs_val | op_b;
            // Shifts move rs by the shamt field and ignore the second operand
            ALU_SLL: alu_out = rs_val << shamt;
            ALU_SRL: alu_out = rs_val >> shamt;
            ALU_SLT: alu_out = ($signed(rs_val) < $signed(op_b)) ? word_t'(1) : '0;
            default: alu_out = rs_val + op_b;
        endcase
    end

    // For sw the result carries the store data to the controller
    assign result   = (op_class == STORE_WORD) ? rt_val : alu_out;
    assign mem_addr = rs_val[`CPU_MEM_ADDR_W-1:0] + imm_ext[`CPU_MEM_ADDR_W-1:0];

    assign taken = ((op_class == BRANCH_EQ) && (rs_val == rt_val)) ||
                   ((op_class == BRANCH_NE) && (rs_val != rt_val));

    // Branch offsets count from the instruction after the branch
    always_comb begin
        if (taken) begin
            next_pc = pc + 1'b1 + imm_ext[`CPU_MEM_ADDR_W-1:0];
        end else if (op_class == JUMP) begin
            next_pc = jump_target;
        end else begin
            next_pc = pc + 1'b1;
        end
    end

endmodule

// ==== hw/instr_decoder.sv ====
// Purely combinational field split and operation classification
// Unknown opcodes and function codes come out as NOP
`timescale 1ns/1ps

module instr_decoder (
    input  cpu_pkg::word_t     ir,
    output cpu_pkg::op_class_t op_class,
    output cpu_pkg::alu_op_t   alu_op,
    output cpu_pkg::reg_addr_t rs,
    output cpu_pkg::reg_addr_t rt,
    output cpu_pkg::reg_addr_t rd,
    output logic [4:0]         shamt,
    output cpu_pkg::imm_t      imm,
    output cpu_pkg::mem_addr_t jump_target
);
    import cpu_pkg::*;

    opcode_t    opcode;
    logic [5:0] funct;

    // Fields sit at fixed positions for every format
    assign opcode      = opcode_t'(ir[31:26]);
    assign rs          = ir[25:21];
    assign rt          = ir[20:16];
    assign rd          = ir[15:11];
    assign shamt       = ir[10:6];
    assign funct       = ir[5:0];
    assign imm         = ir[15:0];
    // Only the low bits of the 26-bit target reach the 8-bit PC
    assign jump_target = ir[7:0];

    always_comb begin
        op_class = NOP;
        alu_op   = ALU_ADD;
        case (opcode)
            // Opcode 0 carries add and sub in the function field
            OP_RTYPE: begin
                if (funct == 6'd0) begin
                    op_class = ALU_REG;
                end else if (funct == 6'd1) begin
                    op_class = ALU_REG;
                    alu_op   = ALU_SUB;
                end
            end
            OP_AND: begin
                op_class = (funct == 6'd0) ? ALU_REG : NOP;
                alu_op   = ALU_AND;
            end
            OP_OR: begin
                op_class = (funct == 6'd0) ? ALU_REG : NOP;
                alu_op   = ALU_OR;
            end
            OP_SLT: begin
                op_class = (funct == 6'd0) ? ALU_REG : NOP;
                alu_op   = ALU_SLT;
            end
            // Shifts use the shamt field and write rd like other register forms
            OP_SHIFT: begin
                op_class = (funct <= 6'd1) ? ALU_REG : NOP;
                alu_op   = (funct == 6'd1) ? ALU_SRL : ALU_SLL;
            end
            OP_ADDI: op_class = ALU_IMM;
            OP_ANDI: begin
                op_class = ALU_IMM;
                alu_op   = ALU_AND;
            end
            OP_ORI: begin
                op_class = ALU_IMM;
                alu_op   = ALU_OR;
            end
            OP_SLTI: begin
                op_class = ALU_IMM;
                alu_op   = ALU_SLT;
            end
            OP_LW:  op_class = LOAD_WORD;
            OP_SW:  op_class = STORE_WORD;
            OP_BEQ: op_class = BRANCH_EQ;
            OP_BNE: op_class = BRANCH_NE;
            OP_J:   op_class = JUMP;
            // Dropped instructions only advance the PC
            OP_ADDIU, OP_BGT, OP_JR, OP_JAL, OP_SYSCALL: op_class = NOP;
            default: op_class = NOP;
        endcase
    end

endmodule

// ==== hw/mem_if.sv ====
// One memory's write port and synchronous read port
// rdata follows raddr by one clock
`timescale 1ns/1ps

interface mem_if;
    import cpu_pkg::*;

    logic      we;
    mem_addr_t waddr;
    word_t     wdata;
    mem_addr_t raddr;
    word_t     rdata;

    // The controller owns the addresses and the write data
    modport ctrl (output we, output waddr, output wdata, output raddr, input rdata);

    // The memory returns the registered read data
    modport mem (input we, input waddr, input wdata, input raddr, output rdata);

endinterface

// ==== hw/register_file.sv ====
// Two combinational read ports, one write port and an inspection read
// Register 0 ignores writes and always reads zero
`timescale 1ns/1ps
`include "cpu_consts.svh"

module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  logic               wr_en,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  cpu_pkg::word_t     wr_data,
    input  cpu_pkg::reg_addr_t insp_addr,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data,
    output cpu_pkg::word_t     insp_data
);
    import cpu_pkg::*;

    word_t regs [`CPU_REG_COUNT];

    // Every register clears on reset, the write lands on the clock edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data   = regs[rs_addr];
    assign rt_data   = regs[rt_addr];
    assign insp_data = regs[insp_addr];

    // Holds across all runs, including writes the controller aims at register 0
    reg_zero_a: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0);

endmodule

// ==== hw/word_memory.sv ====
// Storage is not reset, so only words written since power-up read back defined
// Reading an address in the cycle it is written returns the old word
`timescale 1ns/1ps
`include "cpu_consts.svh"

module word_memory (
    input  logic               clk,
    mem_if.mem                 bus,
    input  cpu_pkg::mem_addr_t insp_addr,
    output cpu_pkg::word_t     insp_data
);
    import cpu_pkg::*;

    word_t storage [`CPU_MEM_DEPTH];

    // One write and one registered read per clock
    always_ff @(posedge clk) begin
        if (bus.we) begin
            storage[bus.waddr] <= bus.wdata;
        end
        bus.rdata <= storage[bus.raddr];
    end

    // The inspection port looks straight into the array and needs no clock
    assign insp_data = storage[insp_addr];

    // A write with an unknown address would corrupt an unpredictable word
    waddr_known_a: assert property (
        @(posedge clk) bus.we |-> !$isunknown(bus.waddr)
    );

endmodule

// ==== test/tb_cpu.sv ====
// Random programs run on the core and are compared with an instruction-level model
// Every run preloads all 256 data words, so lw never reads an unwritten location
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int DONE_LIMIT = 5000;
    // Opcodes of the ALU group, picked with equal weight
    localparam logic [59:0] ALU_OPCODES = {6'd0, 6'd0, 6'd3, 6'd4, 6'd19, 6'd7, 6'd1, 6'd5,
                                           6'd6, 6'd20};

    logic      clk;
    logic      rst_n;
    logic      load_valid;
    word_t     load_data;
    logic      load_to_data;
    logic      load_ready;
    logic      start;
    logic      done;
    logic      insp_is_mem;
    mem_addr_t insp_addr;
    word_t     insp_data;

    // Program of the current run and the state the model expects
    word_t prog [256];
    word_t model_mem [256];
    word_t model_regs [32];

    cpu_top dut_i (.clk, .rst_n, .load_valid, .load_data, .load_to_data, .load_ready, .start,
        .done, .insp_is_mem, .insp_addr, .insp_data);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic expect_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // The inspection path is combinational, so it is read 1 ns after driving the address
    task automatic read_port(input logic is_mem, input int addr, output word_t val);
        @(negedge clk);
        insp_is_mem = is_mem;
        insp_addr   = mem_addr_t'(addr);
        #1 val = insp_data;
    endtask

    // Leaves valid high on return, so the next word can follow without a gap
    task automatic send_word(input logic to_data, input word_t w, input logic with_start);
        int gap;
        int t;
        gap = $urandom_range(2);
        if (gap > 0) begin
            load_valid = 1'b0;
            repeat (gap) @(negedge clk);
        end
        load_valid   = 1'b1;
        load_data    = w;
        load_to_data = to_data;
        start        = with_start;
        t = 0;
        while (!load_ready) begin
            assert (t < 100) else abort_run("load_ready stayed low while loading");
            @(negedge clk);
            t++;
        end
        @(negedge clk);
        start = 1'b0;
    endtask

    // Kind 0 is ALU only, 1 adds lw/sw, 2 adds branches, jumps and unknown opcodes, 3 mixes
    function automatic word_t gen_instr(input int kind, input int idx);
        word_t w;
        int    alu;
        int    r;
        int    op;
        w   = $urandom;
        alu = int'(ALU_OPCODES[6 * $urandom_range(9) +: 6]);
        r   = $urandom_range(4);
        if (kind == 3) kind = $urandom_range(2);
        if (kind == 0) op = alu;
        else if (kind == 1) op = $urandom_range(1) ? alu : 8 + $urandom_range(1);
        else op = (r == 0) ? alu : (r == 1) ? 10 : (r == 2) ? 11 : (r == 3) ? 16 :
                  21 + $urandom_range(42);
        w[31:26] = 6'(op);
        // A bad function code now and then turns the R form into a no-op
        if (op == 0 || op == 7) begin
            w[5:0] = ($urandom_range(7) == 0) ? w[5:0] : 6'($urandom_range(1));
        end
        if (op == 3 || op == 4 || op == 19) w[5:0] = ($urandom_range(7) == 0) ? w[5:0] : 6'd0;
        if (op == 10 || op == 11) begin
            w[15:0] = 16'($urandom_range(3));
            if ($urandom_range(1)) w[20:16] = w[25:21];
        end
        if (op == 16) w[7:0] = 8'(idx + 1 + $urandom_range(3));
        return w;
    endfunction

    task automatic run_model(input int n);
        mem_addr_t  pc;
        mem_addr_t  npc;
        mem_addr_t  addr;
        word_t      w;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      res;
        logic [5:0] op;
        logic [5:0] fn;
        int         dst;
        pc = '0;
        while (int'(pc) < n) begin
            w    = prog[pc];
            op   = w[31:26];
            fn   = w[5:0];
            a    = model_regs[w[25:21]];
            b    = model_regs[w[20:16]];
            imm  = {{16{w[15]}}, w[15:0]};
            npc  = pc + 8'd1;
            addr = a[7:0] + w[7:0];
            res  = '0;
            case (op)
                6'd0:  res = (fn == 6'd1) ? a - b : a + b;
                6'd3:  res = a & b;
                6'd4:  res = a | b;
                6'd19: res = word_t'($signed(a) < $signed(b));
                6'd7:  res = (fn == 6'd1) ? a >> w[10:6] : a << w[10:6];
                6'd1:  res = a + imm;
                6'd5:  res = a & imm;
                6'd6:  res = a | imm;
                6'd20: res = word_t'($signed(a) < $signed(imm));
                6'd8:  res = model_mem[addr];
                6'd9:  model_mem[addr] = b;
                6'd10: if (a == b) npc = pc + 8'd1 + w[7:0];
                6'd11: if (a != b) npc = pc + 8'd1 + w[7:0];
                6'd16: npc = w[7:0];
                default: ;
            endcase
            if (op == 6'd0 || op == 6'd7) begin
                dst = (fn <= 6'd1) ? int'(w[15:11]) : 0;
            end else if (op == 6'd3 || op == 6'd4 || op == 6'd19) begin
                dst = (fn == 6'd0) ? int'(w[15:11]) : 0;
            end else if (op inside {6'd1, 6'd5, 6'd6, 6'd8, 6'd20}) begin
                dst = int'(w[20:16]);
            end else begin
                dst = 0;
            end
            if (dst != 0) model_regs[dst] = res;
            pc = npc;
        end
    endtask

    task automatic run_program(input int kind, input int n);
        word_t got;
        int    sent_i;
        int    sent_d;
        int    t;
        apply_reset();
        expect_word("load_ready", word_t'(load_ready), 32'd1);
        expect_word("done", word_t'(done), 32'd0);
        for (int r = 0; r < 32; r++) begin
            read_port(1'b0, r, got);
            expect_word($sformatf("reg[%0d] after reset", r), got, '0);
            model_regs[r] = '0;
        end
        for (int i = 0; i < n; i++) prog[i] = gen_instr(kind, i);
        for (int i = 0; i < 256; i++) model_mem[i] = $urandom;
        // Both streams interleave at random and the last instruction goes out with start
        sent_i = 0;
        sent_d = 0;
        while (sent_d < 256 || sent_i < n - 1) begin
            if (sent_d < 256 && (sent_i >= n - 1 || $urandom_range(1))) begin
                send_word(1'b1, model_mem[sent_d], 1'b0);
                sent_d++;
            end else begin
                send_word(1'b0, prog[sent_i], 1'b0);
                sent_i++;
            end
        end
        load_valid = 1'b0;
        for (int i = 0; i < 256; i++) begin
            read_port(1'b1, i, got);
            expect_word($sformatf("dmem[%0d] after load", i), got, model_mem[i]);
        end
        if (n > 0) begin
            send_word(1'b0, prog[n - 1], 1'b1);
        end else begin
            @(negedge clk);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        load_valid = 1'b0;
        t = 0;
        while (!done) begin
            assert (t < DONE_LIMIT) else abort_run("done did not rise before the timeout");
            expect_word("load_ready", word_t'(load_ready), 32'd0);
            @(negedge clk);
            t++;
        end
        repeat (50) begin
            @(negedge clk);
            expect_word("done", word_t'(done), 32'd1);
            expect_word("load_ready", word_t'(load_ready), 32'd0);
        end
        run_model(n);
        for (int i = 0; i < 256; i++) begin
            read_port(1'b1, i, got);
            expect_word($sformatf("dmem[%0d]", i), got, model_mem[i]);
            if (i < 32) begin
                read_port(1'b0, i, got);
                expect_word($sformatf("reg[%0d]", i), got, model_regs[i]);
            end
        end
    endtask

    initial begin
        void'($urandom(32'hd174fb6b));
        rst_n        = 1'b0;
        load_valid   = 1'b0;
        load_data    = '0;
        load_to_data = 1'b0;
        start        = 1'b0;
        insp_is_mem  = 1'b0;
        insp_addr    = '0;
        run_program(0, 30);
        run_program(1, 30);
        run_program(2, 30);
        run_program(3, 0);
        run_program(3, 40);
        run_program(1, 25);
        run_program(2, 35);
        $display("Test completed successfully");
        $finish;
    end

endmodule
